/* build.f */
src/wisc_pkg.sv
src/instr_latch.sv
src/imm_extend.sv
src/ctrl_decode.sv
src/reg_file.sv
src/decode_out_reg.sv
src/decode_stage.sv
tests/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
# Builds the decode stage testbench with Verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f build.f --top-module decode_stage_tb \
	-o decode_stage_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/decode_stage_sim > sim.log 2>&1 || echo "simulator exited with an error"
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation did not finish, see sim.log"; exit 1; }
echo "simulation passed"

/* tests/decode_golden.txt */
// kind instr/reg ctrl/data rd rs_val rt_val imm (kind 1 write, 2 decode, 3 idle, 0 end)
// write lines use only the register and data columns.
3 0000 0000 0 0000 0000 0000
3 0000 0000 0 0000 0000 0000
1 0000 0F0F 0 0000 0000 0000
1 0001 1111 0 0000 0000 0000
1 0002 2222 0 0000 0000 0000
1 0003 3333 0 0000 0000 0000
1 0004 4444 0 0000 0000 0000
1 0005 5555 0 0000 0000 0000
1 0006 6666 0 0000 0000 0000
1 0007 7777 0 0000 0000 0000
2 414F 0180 2 1111 2222 000F
2 4B91 1180 4 3333 4444 FFF1
2 55DA 2180 6 5555 6666 001A
2 5F05 3180 0 7777 0F0F 0005
2 A233 4180 1 2222 1111 FFF3
2 B864 7180 3 0F0F 3333 0004
2 84BF 0120 5 4444 5555 FFFF
2 8EE7 01C0 7 6666 7777 0007
2 9910 01A0 0 1111 0F0F FFF0
2 627F 0800 3 2222 3333 007F
2 7580 0C00 4 5555 4444 FF80
2 7801 0E00 0 0F0F 0F0F 0001
2 C3C8 D180 3 3333 6666 FFC8
2 96A5 E180 6 6666 5555 00A5
2 913C E180 1 1111 1111 003C
2 C425 D180 4 4444 1111 0025
2 23FF 0010 7 3333 7777 03FF
2 3400 0094 7 4444 0F0F FC00
2 2DF0 0118 7 5555 7777 FFF0
2 3A12 019C 7 2222 0F0F 0012
2 D94D 1080 3 1111 2222 000D
2 D6B2 6080 4 6666 5555 FFF2
2 EF28 9080 2 7777 1111 0008
2 CB14 C080 5 3333 0F0F FFF4
2 0000 0002 0 0F0F 0F0F 0000
2 0800 0000 0 0F0F 0F0F 0000
2 1143 0001 2 1111 2222 0003
3 0000 0000 0 0000 0000 0000
1 0003 BEEF 0 0000 0000 0000
2 4300 0180 0 BEEF 0F0F 0000
0 0000 0000 0 0000 0000 0000

/* tests/decode_stage_tb.sv */
// ########################################
// decode_stage_tb drives the decode stage
// from the golden file and checks it.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module decode_stage_tb
	import wisc_pkg::*;
();

	localparam int CMD_WORDS   = 7;  // hex words per golden line.
	localparam int MAX_CMDS    = 64;
	localparam int DRAIN_LIMIT = 20; // cycles allowed for the last outputs.

	localparam logic [15:0] KIND_END    = 16'h0;
	localparam logic [15:0] KIND_WRITE  = 16'h1;
	localparam logic [15:0] KIND_DECODE = 16'h2;
	localparam logic [15:0] KIND_IDLE   = 16'h3;

	// one expected output cycle and the cycle it was driven in.
	typedef struct packed {
		logic [31:0] cyc;
		logic        valid;
		logic [15:0] ctrl;
		logic [15:0] rd;
		word_t       rs_val;
		word_t       rt_val;
		word_t       imm;
	} expect_t;

	logic     clk;
	logic     rst;
	logic     instr_valid;
	word_t    instr;
	logic     wr_en;
	reg_idx_t wr_reg;
	word_t    wr_data;
	logic     out_valid;
	decoded_t dec;

	logic [15:0] golden [CMD_WORDS * MAX_CMDS];
	expect_t     pending [$];
	logic [31:0] cyc; // rising edges since reset release.

	decode_stage uut (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wr_en       (wr_en),
		.wr_reg      (wr_reg),
		.wr_data     (wr_data),
		.out_valid   (out_valid),
		.dec         (dec)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("FAIL time=%0t %s expected %h got %h", $time, name, expected, actual);
			abort_run();
		end
	endtask

	// outputs are stable at the falling edge.
	always @(negedge clk) begin
		expect_t e;
		if (pending.size() > 0 && pending[0].cyc + 32'd2 == cyc) begin
			e = pending.pop_front();
			check_field("out_valid", {15'b0, e.valid}, {15'b0, out_valid});
			if (e.valid) begin
				check_field("dec.ctrl", e.ctrl, dec.ctrl);
				check_field("dec.rd", e.rd, {13'b0, dec.rd});
				check_field("dec.rs_val", e.rs_val, dec.rs_val);
				check_field("dec.rt_val", e.rt_val, dec.rt_val);
				check_field("dec.imm", e.imm, dec.imm);
			end
		end else if (rst === 1'b0) begin
			// out_valid stays low when no item is due.
			check_field("out_valid", 16'h0000, {15'b0, out_valid});
		end
	end

	initial begin
		int          idx;
		int          base;
		int          drain;
		logic        done;
		logic [15:0] kind;
		expect_t     e;
		rst         <= 1'b1;
		instr_valid <= 1'b0;
		instr       <= '0;
		wr_en       <= 1'b0;
		wr_reg      <= '0;
		wr_data     <= '0;
		cyc  = '0;
		done = 1'b0;
		$readmemh("tests/decode_golden.txt", golden);
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		for (idx = 0; idx < MAX_CMDS && !done; idx++) begin
			@(posedge clk);
			cyc  = cyc + 32'd1;
			base = idx * CMD_WORDS;
			kind = golden[base];
			if (kind == KIND_END) begin
				done = 1'b1;
				instr_valid <= 1'b0;
				wr_en       <= 1'b0;
			end else if (kind > KIND_IDLE) begin
				$display("ERROR: golden file line %0d has an unknown command kind", idx);
				abort_run();
			end else begin
				instr_valid <= (kind == KIND_DECODE);
				wr_en       <= (kind == KIND_WRITE);
				instr       <= golden[base + 1];
				wr_reg      <= golden[base + 1][2:0];
				wr_data     <= golden[base + 2];
				e.cyc    = cyc;
				e.valid  = (kind == KIND_DECODE);
				e.ctrl   = golden[base + 2];
				e.rd     = golden[base + 3];
				e.rs_val = golden[base + 4];
				e.rt_val = golden[base + 5];
				e.imm    = golden[base + 6];
				pending.push_back(e);
			end
		end

		// let the last items leave the pipe.
		drain = 0;
		while (pending.size() > 0 && drain < DRAIN_LIMIT) begin
			@(posedge clk);
			cyc = cyc + 32'd1;
			drain++;
		end
		if (pending.size() > 0) begin
			$display("ERROR: decode output never arrived for %0d instructions", pending.size());
			abort_run();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// ########################################
// decode_stage: latch, decode, register
// read and output register, two cycles.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module decode_stage
	import wisc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     instr_valid,
	input  word_t    instr,
	input  logic     wr_en,
	input  reg_idx_t wr_reg,
	input  word_t    wr_data,
	output logic     out_valid,
	output decoded_t dec
);

	logic     lat_valid;
	word_t    lat_instr;
	word_t    imm;
	ctrl_t    ctrl;
	reg_idx_t rs_idx;
	reg_idx_t rt_idx;
	reg_idx_t rd_idx;
	word_t    rs_val;
	word_t    rt_val;

	instr_latch u_instr_latch (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.lat_valid   (lat_valid),
		.lat_instr   (lat_instr)
	);

	imm_extend u_imm_extend (
		.instr (lat_instr),
		.imm   (imm)
	);

	ctrl_decode u_ctrl_decode (
		.instr  (lat_instr),
		.ctrl   (ctrl),
		.rs_idx (rs_idx),
		.rt_idx (rt_idx),
		.rd_idx (rd_idx)
	);

	// operands are read in the latch cycle.
	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (wr_en),
		.wr_reg  (wr_reg),
		.wr_data (wr_data),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.rs_val  (rs_val),
		.rt_val  (rt_val)
	);

	decode_out_reg u_decode_out_reg (
		.clk       (clk),
		.rst       (rst),
		.lat_valid (lat_valid),
		.ctrl      (ctrl),
		.rd_idx    (rd_idx),
		.rs_val    (rs_val),
		.rt_val    (rt_val),
		.imm       (imm),
		.out_valid (out_valid),
		.dec       (dec)
	);

endmodule

`default_nettype wire

/* src/decode_out_reg.sv */
// ########################################
// decode_out_reg: registers the decoded
// bundle and its valid pulse.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module decode_out_reg
	import wisc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     lat_valid,
	input  ctrl_t    ctrl,
	input  reg_idx_t rd_idx,
	input  word_t    rs_val,
	input  word_t    rt_val,
	input  word_t    imm,
	output logic     out_valid,
	output decoded_t dec
);

	decoded_t dec_next;

	always_comb begin
		dec_next.ctrl   = ctrl;
		dec_next.rd     = rd_idx;
		dec_next.rs_val = rs_val;
		dec_next.rt_val = rt_val;
		dec_next.imm    = imm;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= lat_valid; // one cycle behind the latch.
		end
	end

	always_ff @(posedge clk) begin
		if (lat_valid) begin
			dec <= dec_next;
		end
	end

endmodule

`default_nettype wire

/* src/reg_file.sv */
// ########################################
// reg_file: eight 16 bit registers with
// two read ports and one write port.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module reg_file
	import wisc_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     wr_en,
	input  reg_idx_t wr_reg,
	input  word_t    wr_data,
	input  reg_idx_t rs_idx,
	input  reg_idx_t rt_idx,
	output word_t    rs_val,
	output word_t    rt_val
);

	word_t regs [NUM_REGS];

	// register 0 is writable like any other.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_reg] <= wr_data;
		end
	end

	// no write bypass.
	assign rs_val = regs[rs_idx];
	assign rt_val = regs[rt_idx];

endmodule

`default_nettype wire

/* src/ctrl_decode.sv */
// ########################################
// ctrl_decode: opcode to control bundle,
// register indices and illegal flag.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module ctrl_decode
	import wisc_pkg::*;
(
	input  word_t    instr,
	output ctrl_t    ctrl,
	output reg_idx_t rs_idx,
	output reg_idx_t rt_idx,
	output reg_idx_t rd_idx
);

	opcode_e    opcode;
	logic [1:0] op_low; // selects within a group of four.
	logic [1:0] funct;

	assign opcode = opcode_e'(instr[15:11]);
	assign op_low = instr[12:11];
	assign funct  = instr[1:0];

	// source fields sit in the same place in every format.
	assign rs_idx = instr[10:8];
	assign rt_idx = instr[7:5];

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_ADD;
		ctrl.branch = BR_NONE;
		rd_idx      = instr[7:5]; // i-format-1 destination.

		case (opcode)
			ADDI, SUBI, XORI, ANDNI: begin
				ctrl.alu_op    = alu_op_e'({2'b00, op_low});
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			ROLI, SLLI, RORI, SRLI: begin
				ctrl.alu_op    = alu_op_e'({2'b01, op_low});
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			ST: begin
				ctrl.use_imm   = 1'b1; // address is rs plus offset.
				ctrl.mem_write = 1'b1;
			end
			LD: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			STU: begin
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.reg_write = 1'b1; // updated address written back.
			end
			BEQZ, BNEZ, BLTZ, BGEZ: begin
				ctrl.branch = branch_e'({1'b1, op_low});
			end
			LBI, SLBI: begin
				ctrl.alu_op    = (opcode == LBI) ? ALU_PASS_B : ALU_SLBI;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				rd_idx         = instr[10:8];
			end
			J: begin
				ctrl.jump = 1'b1;
			end
			JR: begin
				ctrl.jump     = 1'b1;
				ctrl.jump_reg = 1'b1;
				ctrl.use_imm  = 1'b1;
			end
			JAL, JALR: begin
				ctrl.jump      = 1'b1;
				ctrl.jump_reg  = (opcode == JALR);
				ctrl.use_imm   = (opcode == JALR);
				ctrl.link      = 1'b1;
				ctrl.reg_write = 1'b1;
				rd_idx         = 3'd7; // return address register.
			end
			ALU_RR, SHIFT_RR: begin
				ctrl.alu_op    = alu_op_e'({1'b0, (opcode == SHIFT_RR), funct});
				ctrl.reg_write = 1'b1;
				rd_idx         = instr[4:2];
			end
			SEQ, SLT, SLE, SCO: begin
				ctrl.alu_op    = alu_op_e'({2'b10, op_low});
				ctrl.reg_write = 1'b1;
				rd_idx         = instr[4:2];
			end
			BTR: begin
				ctrl.alu_op    = ALU_BTR;
				ctrl.reg_write = 1'b1;
				rd_idx         = instr[4:2];
			end
			HALT: begin
				ctrl.halt = 1'b1;
			end
			NOP: begin
				ctrl = '0;
			end
			// undefined encodings leave write and memory flags clear.
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/imm_extend.sv */
// ########################################
// imm_extend zero or sign extends the
// 5, 8 or 11 bit immediate field.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module imm_extend
	import wisc_pkg::*;
(
	input  word_t instr,
	output word_t imm
);

	opcode_e     opcode;
	logic [4:0]  field5;
	logic [7:0]  field8;
	logic [10:0] field11;

	assign opcode  = opcode_e'(instr[15:11]);
	assign field5  = instr[4:0];
	assign field8  = instr[7:0];
	assign field11 = instr[10:0];

	always_comb begin
		case (opcode)
			// jump displacement.
			J, JAL: begin
				imm = {{5{field11[10]}}, field11};
			end

			// logical immediates are unsigned.
			XORI, ANDNI: begin
				imm = {11'h000, field5};
			end

			// byte load, register jumps and branch offsets.
			LBI, JR, JALR, BEQZ, BNEZ, BLTZ, BGEZ: begin
				imm = {{8{field8[7]}}, field8};
			end

			// low byte shifted in below rs.
			SLBI: begin
				imm = {8'h00, field8};
			end

			// arithmetic, memory, shifts and rotates.
			default: begin
				imm = {{11{field5[4]}}, field5};
			end
		endcase
	end

endmodule

`default_nettype wire

/* src/instr_latch.sv */
// ########################################
// instr_latch: captures an instruction on
// its valid strobe for the decode cycle.
// ########################################
`timescale 1ns/1ns
`default_nettype none

module instr_latch
	import wisc_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  instr_valid,
	input  word_t instr,
	output logic  lat_valid,
	output word_t lat_instr
);

	// valid flag follows the strobe every cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			lat_valid <= 1'b0;
		end else begin
			lat_valid <= instr_valid;
		end
	end

	// holds its last value between strobes.
	always_ff @(posedge clk) begin
		if (instr_valid) begin
			lat_instr <= instr;
		end
	end

endmodule

`default_nettype wire

/* src/wisc_pkg.sv */
// ########################################
// wisc_pkg: ISA types and decoded bundles
// shared by the decode stage.
// ########################################
`default_nettype none

package wisc_pkg;

	localparam int NUM_REGS = 8; // architectural registers.

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;

	// opcode sits in instr[15:11].
	typedef enum logic [4:0] {
		HALT     = 5'b00000,
		NOP      = 5'b00001,
		J        = 5'b00100,
		JR       = 5'b00101,
		JAL      = 5'b00110,
		JALR     = 5'b00111,
		ADDI     = 5'b01000,
		SUBI     = 5'b01001,
		XORI     = 5'b01010,
		ANDNI    = 5'b01011,
		BEQZ     = 5'b01100,
		BNEZ     = 5'b01101,
		BLTZ     = 5'b01110,
		BGEZ     = 5'b01111,
		ST       = 5'b10000,
		LD       = 5'b10001,
		SLBI     = 5'b10010,
		STU      = 5'b10011,
		ROLI     = 5'b10100,
		SLLI     = 5'b10101,
		RORI     = 5'b10110,
		SRLI     = 5'b10111,
		LBI      = 5'b11000,
		BTR      = 5'b11001,
		SHIFT_RR = 5'b11010,
		ALU_RR   = 5'b11011,
		SEQ      = 5'b11100,
		SLT      = 5'b11101,
		SLE      = 5'b11110,
		SCO      = 5'b11111
	} opcode_e;

	// low two bits of each group line up with the opcode and funct bits.
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_XOR    = 4'd2,
		ALU_ANDN   = 4'd3,
		ALU_ROL    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_ROR    = 4'd6,
		ALU_SRL    = 4'd7,
		ALU_SEQ    = 4'd8,
		ALU_SLT    = 4'd9,
		ALU_SLE    = 4'd10,
		ALU_SCO    = 4'd11,
		ALU_BTR    = 4'd12,
		ALU_PASS_B = 4'd13, // lbi.
		ALU_SLBI   = 4'd14
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'b000,
		BR_EQZ  = 3'b100,
		BR_NEZ  = 3'b101,
		BR_LTZ  = 3'b110,
		BR_GEZ  = 3'b111
	} branch_e;

	typedef struct packed {
		alu_op_e alu_op;
		branch_e branch;
		logic    use_imm;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    jump;
		logic    jump_reg;
		logic    link;
		logic    halt;
		logic    illegal;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;
	} decoded_t;

endpackage

`default_nettype wire
